// File: logic/ctxPkg.sv
`default_nettype none

package ctxPkg;

	// ----------------------------------------
	// sizes
	// ----------------------------------------
	// free-object RAM geometry
	localparam int ramDepth = 256;
	localparam int ramAddrWidth = 8;
	// width of the free and cached memory counters
	localparam int memWidth = 40;

	// ----------------------------------------
	// control word layout
	// ----------------------------------------
	// core start pulse
	localparam int ctlCoreStart = 3;
	// cache opcode in bits 6:4
	localparam int ctlOpLsb = 4;
	// ready level request
	localparam int ctlReady = 11;
	// free memory method, two bits
	localparam int ctlMemOpLsb = 12;
	// core stop pulse
	localparam int ctlCoreStop = 16;

	// I/O port numbers seen on the write port
	typedef enum logic [3:0] {
		portNone = 4'd0,
		portControl = 4'd3,
		portLength = 4'd6,
		portSel = 4'd7
	} ioPort_t;

	// one write from the microcontroller side
	typedef struct packed {
		ioPort_t port;
		logic [31:0] data;
	} ioWrite_t;

	// free cache operations
	typedef enum logic [2:0] {
		opNone = 3'd0,
		opWrite = 3'd1,
		opClear = 3'd2,
		opFree = 3'd3,
		opCalc = 3'd4,
		opSearch = 3'd5,
		opEmptyFree = 3'd6,
		opEmptySearch = 3'd7
	} cacheOp_t;

	// free memory counter update methods
	typedef enum logic [1:0] {
		memKeep,
		memClear,
		memAdd,
		memSub
	} freeMemOp_t;

	// RAM word, selector on top
	typedef struct packed {
		logic [23:0] sel;
		logic [31:0] length;
	} freeEntry_t;

	// scanner results
	typedef struct packed {
		logic busy;
		logic freeFound;
		logic lengthFound;
		logic emptyFound;
		freeEntry_t found;
		logic [ramAddrWidth-1:0] foundAddr;
		logic [memWidth-1:0] cachedMem;
	} cacheStatus_t;

endpackage

`default_nettype wire

// File: logic/commandDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module commandDecoder import ctxPkg::*; (
	input wire CLK,
	input wire RESETn,
	input wire cena,
	input wire malockf,
	input wire ioWrite_t ioWr,
	output cacheOp_t cacheReq,
	output freeEntry_t entry,
	output logic ready,
	output logic coreStart,
	output logic coreStop,
	output logic [memWidth-1:0] freeMem
);

	// port hits
	logic ctlWr;
	logic lengthWr;
	logic selWr;
	// fields of the control word
	cacheOp_t ctlOp;
	freeMemOp_t memOp;
	// length widened to the counter width
	logic [memWidth-1:0] lengthExt;
	// next free memory value
	logic [memWidth-1:0] freeMemNext;

	// ----------------------------------------
	// write decode
	// ----------------------------------------
	always_comb begin
		ctlWr = (ioWr.port == portControl);
		lengthWr = (ioWr.port == portLength);
		selWr = (ioWr.port == portSel);
		ctlOp = cacheOp_t'(ioWr.data[ctlOpLsb +: $bits(cacheOp_t)]);
		memOp = freeMemOp_t'(ioWr.data[ctlMemOpLsb +: $bits(freeMemOp_t)]);
		lengthExt = {{(memWidth - 32){1'b0}}, entry.length};
	end

	// free memory accounting, uses the length already latched
	always_comb begin
		freeMemNext = freeMem;
		case (memOp)
			memClear: begin
				freeMemNext = '0;
			end
			memAdd: begin
				freeMemNext = freeMem + lengthExt;
			end
			memSub: begin
				// released block counts one extra unit
				freeMemNext = freeMem - lengthExt - 1'b1;
			end
			default: begin
				freeMemNext = freeMem;
			end
		endcase
	end

	// ----------------------------------------
	// length and selector registers
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		if (lengthWr) begin
			entry.length <= ioWr.data;
		end
		// upper byte of the selector port ignored
		if (selWr) begin
			entry.sel <= ioWr.data[23:0];
		end
	end

	// ----------------------------------------
	// pulses, levels and counter
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			cacheReq <= opNone;
			coreStart <= 1'b0;
			coreStop <= 1'b0;
			ready <= 1'b0;
			freeMem <= '0;
		end else begin
			// one cycle request to the scanner
			cacheReq <= ctlWr ? ctlOp : opNone;
			// core control strobes
			coreStart <= ctlWr && ioWr.data[ctlCoreStart];
			coreStop <= ctlWr && ioWr.data[ctlCoreStop];
			// ready holds only while enabled and not locked
			ready <= (ready || (ctlWr && ioWr.data[ctlReady])) && cena && !malockf;
			if (ctlWr) begin
				freeMem <= freeMemNext;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/freeObjectRam.sv
`timescale 1ns/1ps
`default_nettype none

module freeObjectRam import ctxPkg::*; (
	input wire CLK,
	input wire [ramAddrWidth-1:0] addr,
	input wire we,
	input wire freeEntry_t wData,
	output freeEntry_t rData
);

	// storage array
	freeEntry_t mem [ramDepth];

	// known contents from time zero
	initial begin
		for (int i = 0; i < ramDepth; i++) begin
			mem[i] = '0;
		end
	end

	// single port, old data on read during write
	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= wData;
		end
		rData <= mem[addr];
	end

endmodule

`default_nettype wire

// File: logic/freeCacheScanner.sv
`timescale 1ns/1ps
`default_nettype none

module freeCacheScanner import ctxPkg::*; (
	input wire CLK,
	input wire RESETn,
	input wire cacheOp_t cacheReq,
	input wire freeEntry_t entry,
	output logic [ramAddrWidth-1:0] ramAddr,
	output logic ramWe,
	output freeEntry_t ramWData,
	input wire freeEntry_t ramRData,
	output cacheStatus_t status
);

	// opcode and address of one read in flight
	typedef struct packed {
		cacheOp_t op;
		logic [ramAddrWidth-1:0] addr;
	} readStage_t;

	// operation in progress, opNone when idle
	cacheOp_t procOp;
	// RAM address counter
	logic [ramAddrWidth-1:0] addrCnt;
	// read pipeline, index 0 pairs with ramRData
	readStage_t pipe [3];
	// RAM data aligned with pipe[1]
	freeEntry_t rdData;
	// scan finished, one cycle
	logic endFlag;
	// result registers
	logic freeFound;
	logic lengthFound;
	logic emptyFound;
	freeEntry_t found;
	logic [ramAddrWidth-1:0] foundAddr;
	logic [memWidth-1:0] cachedMem;

	// decode helpers
	logic busy;
	logic scanReq;
	logic [ramAddrWidth-1:0] startAddr;
	logic issueLast;
	logic stageValid;
	logic stageLast;
	logic freeMatch;
	logic lengthMatch;
	logic emptyMatch;
	logic anyMatch;

	// last address of the range that op walks
	function automatic logic rangeEnd(input cacheOp_t op, input logic [ramAddrWidth-1:0] addr);
		logic lowerHalf;
		lowerHalf = (op == opEmptyFree) || (op == opEmptySearch);
		return (&addr[ramAddrWidth-2:0]) && (addr[ramAddrWidth-1] == !lowerHalf);
	endfunction

	// ----------------------------------------
	// decode
	// ----------------------------------------
	always_comb begin
		busy = (procOp != opNone);
		scanReq = (cacheReq != opNone) && (cacheReq != opWrite);
		// object scans live in the upper half, descriptor scans in the lower
		startAddr = '0;
		startAddr[ramAddrWidth-1] = (cacheReq == opFree) || (cacheReq == opSearch) ||
			(cacheReq == opCalc);
		issueLast = rangeEnd(procOp, addrCnt);
		// only reads of the running scan count
		stageValid = busy && !endFlag && (pipe[1].op == procOp);
		stageLast = rangeEnd(pipe[1].op, pipe[1].addr);
		// match conditions on stage two
		freeMatch = ((pipe[1].op == opFree) || (pipe[1].op == opEmptyFree)) &&
			(rdData.sel == '0);
		lengthMatch = (pipe[1].op == opSearch) && (rdData.length >= entry.length);
		emptyMatch = (pipe[1].op == opEmptySearch) && (rdData.sel != '0);
		anyMatch = freeMatch || lengthMatch || emptyMatch;
	end

	// RAM side
	always_comb begin
		ramAddr = addrCnt;
		// clear writes zero under the walking counter
		ramWe = (cacheReq == opWrite) || (procOp == opClear);
		ramWData = (procOp == opClear) ? '0 : entry;
	end

	// ----------------------------------------
	// control
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			procOp <= opNone;
			addrCnt <= '0;
			pipe[0] <= '0;
			pipe[1] <= '0;
			pipe[2] <= '0;
			endFlag <= 1'b0;
			freeFound <= 1'b0;
			lengthFound <= 1'b0;
			emptyFound <= 1'b0;
		end else begin
			if (scanReq) begin
				procOp <= cacheReq;
			end else if (endFlag) begin
				procOp <= opNone;
			end

			// start, rewind to stage three, or step
			if (scanReq) begin
				addrCnt <= startAddr;
			end else if (endFlag) begin
				addrCnt <= pipe[2].addr;
			end else if (busy && !issueLast) begin
				addrCnt <= addrCnt + 1'b1;
			end

			// counter parks on the last address
			// repeated reads there are cut off by endFlag
			pipe[0].op <= (busy && !endFlag) ? procOp : opNone;
			pipe[0].addr <= addrCnt;
			pipe[1] <= pipe[0];
			pipe[2] <= pipe[1];

			// stop at the first hit or the end of range
			endFlag <= stageValid && (anyMatch || stageLast);

			// found flags
			if ((cacheReq == opFree) || (cacheReq == opEmptyFree)) begin
				freeFound <= 1'b0;
			end else if (stageValid && freeMatch) begin
				freeFound <= 1'b1;
			end
			if (cacheReq == opSearch) begin
				lengthFound <= 1'b0;
			end else if (stageValid && lengthMatch) begin
				lengthFound <= 1'b1;
			end
			if (cacheReq == opEmptySearch) begin
				emptyFound <= 1'b0;
			end else if (stageValid && emptyMatch) begin
				emptyFound <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// data path
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		rdData <= ramRData;
		// matched object, same edge as lengthFound
		if (stageValid && lengthMatch) begin
			found <= rdData;
		end
		// final write address of the scan
		if (endFlag) begin
			foundAddr <= pipe[2].addr;
		end
		// sum of cached lengths
		if (cacheReq == opCalc) begin
			cachedMem <= '0;
		end else if (stageValid && (pipe[1].op == opCalc)) begin
			cachedMem <= cachedMem + {{(memWidth - 32){1'b0}}, rdData.length};
		end
	end

	always_comb begin
		status.busy = busy;
		status.freeFound = freeFound;
		status.lengthFound = lengthFound;
		status.emptyFound = emptyFound;
		status.found = found;
		status.foundAddr = foundAddr;
		status.cachedMem = cachedMem;
	end

endmodule

`default_nettype wire

// File: logic/contextController.sv
`timescale 1ns/1ps
`default_nettype none

module contextController import ctxPkg::*; (
	input wire CLK,
	input wire RESETn,
	input wire cena,
	input wire malockf,
	input wire ioWrite_t ioWr,
	output logic ready,
	output logic coreStart,
	output logic coreStop,
	output logic [memWidth-1:0] freeMem,
	output cacheStatus_t status
);

	// decoder to scanner
	cacheOp_t cacheReq;
	freeEntry_t entry;
	// scanner to RAM
	logic [ramAddrWidth-1:0] ramAddr;
	logic ramWe;
	freeEntry_t ramWData;
	freeEntry_t ramRData;

	// I/O write decode
	commandDecoder commandDecoder_inst (
		.CLK(CLK),
		.RESETn(RESETn),
		.cena(cena),
		.malockf(malockf),
		.ioWr(ioWr),
		.cacheReq(cacheReq),
		.entry(entry),
		.ready(ready),
		.coreStart(coreStart),
		.coreStop(coreStop),
		.freeMem(freeMem)
	);

	// scan engine
	freeCacheScanner freeCacheScanner_inst (
		.CLK(CLK),
		.RESETn(RESETn),
		.cacheReq(cacheReq),
		.entry(entry),
		.ramAddr(ramAddr),
		.ramWe(ramWe),
		.ramWData(ramWData),
		.ramRData(ramRData),
		.status(status)
	);

	// free object cache storage
	freeObjectRam freeObjectRam_inst (
		.CLK(CLK),
		.addr(ramAddr),
		.we(ramWe),
		.wData(ramWData),
		.rData(ramRData)
	);

endmodule

`default_nettype wire

// File: verification/contextController_sva.sv
`timescale 1ns/1ps
`default_nettype none

module contextControllerSva import ctxPkg::*; (
	input wire CLK,
	input wire RESETn,
	input wire cacheOp_t procOp,
	input wire ramWe,
	input wire freeEntry_t entry,
	input wire cacheStatus_t status
);

	// scanner idle right after reset
	idleAfterReset: assert property (@(posedge CLK) !RESETn |=> !status.busy)
		else $error("scanner busy after reset");

	// only the clear scan writes while busy
	clearOnlyWrites: assert property (@(posedge CLK) disable iff (!RESETn)
		(status.busy && ramWe) |-> (procOp == opClear))
		else $error("RAM written during a scan other than clear");

	// a new length match is long enough
	lengthLongEnough: assert property (@(posedge CLK) disable iff (!RESETn)
		$rose(status.lengthFound) |-> (status.found.length >= entry.length))
		else $error("matched object shorter than the requested length");

endmodule

`default_nettype wire

// File: verification/contextControllerTb.sv
`timescale 1ns/1ps
`default_nettype none

module contextControllerTb import ctxPkg::*; ();

	logic CLK;
	logic RESETn;
	logic cena;
	logic malockf;
	ioWrite_t ioWr;
	logic ready;
	logic coreStart;
	logic coreStop;
	logic [memWidth-1:0] freeMem;
	cacheStatus_t status;

	// model state
	freeEntry_t modelRam [ramDepth];
	logic [ramAddrWidth-1:0] modelAddr;
	cacheStatus_t expStatus;
	logic [memWidth-1:0] expFreeMem;
	// bookkeeping
	logic [15:0] lfsrState;
	int errorCount;
	int checkCount;
	int cycleCount;
	string checkName;
	event checkNow;

	contextController contextController_inst (
		.CLK(CLK),
		.RESETn(RESETn),
		.cena(cena),
		.malockf(malockf),
		.ioWr(ioWr),
		.ready(ready),
		.coreStart(coreStart),
		.coreStop(coreStop),
		.freeMem(freeMem),
		.status(status)
	);

	bind freeCacheScanner contextControllerSva contextControllerSva_inst (
		.CLK(CLK),
		.RESETn(RESETn),
		.procOp(procOp),
		.ramWe(ramWe),
		.entry(entry),
		.status(status)
	);

	// 4 ns clock
	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	// one LFSR step per bit
	function automatic logic [31:0] takeRandomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return value;
	endfunction

	function automatic logic [31:0] ctlWord(input cacheOp_t op, input freeMemOp_t memOp);
		logic [31:0] word;
		word = '0;
		word[ctlOpLsb +: $bits(cacheOp_t)] = op;
		word[ctlMemOpLsb +: $bits(freeMemOp_t)] = memOp;
		return word;
	endfunction

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic void refModel(input cacheOp_t op, input freeEntry_t ent,
		input freeMemOp_t memOp);
		int first;
		int hitAddr;
		logic hit;
		logic match;
		logic [memWidth-1:0] sum;
		// released blocks count one extra unit
		case (memOp)
			memClear: expFreeMem = '0;
			memAdd: expFreeMem = expFreeMem + memWidth'(ent.length);
			memSub: expFreeMem = expFreeMem - memWidth'(ent.length) - memWidth'(1);
			default: expFreeMem = expFreeMem;
		endcase
		if (op == opWrite) begin
			modelRam[modelAddr] = ent;
		end else if (op == opClear) begin
			for (int i = 0; i < ramDepth; i++) begin
				modelRam[i] = '0;
			end
			modelAddr = '1;
			expStatus.foundAddr = '1;
		end else if (op != opNone) begin
			// descriptor scans walk the lower half
			first = ((op == opEmptyFree) || (op == opEmptySearch)) ? 0 : ramDepth / 2;
			hitAddr = first + ramDepth / 2 - 1;
			hit = 1'b0;
			sum = '0;
			for (int i = first; i < first + ramDepth / 2; i++) begin
				case (op)
					opFree, opEmptyFree: match = (modelRam[i].sel == '0);
					opSearch: match = (modelRam[i].length >= ent.length);
					opEmptySearch: match = (modelRam[i].sel != '0);
					default: match = 1'b0;
				endcase
				sum = sum + memWidth'(modelRam[i].length);
				if (match && !hit) begin
					hit = 1'b1;
					hitAddr = i;
				end
			end
			case (op)
				opFree, opEmptyFree: expStatus.freeFound = hit;
				opEmptySearch: expStatus.emptyFound = hit;
				opCalc: expStatus.cachedMem = sum;
				default: expStatus.lengthFound = hit;
			endcase
			if ((op == opSearch) && hit) begin
				expStatus.found = modelRam[hitAddr];
			end
			modelAddr = hitAddr[ramAddrWidth-1:0];
			expStatus.foundAddr = modelAddr;
		end
	endfunction

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error: %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// compare against the model on request
	initial begin
		forever begin
			@(checkNow);
			checkValue({checkName, " busy"}, 64'd0, 64'(status.busy));
			checkValue({checkName, " freeFound"}, 64'(expStatus.freeFound),
				64'(status.freeFound));
			checkValue({checkName, " lengthFound"}, 64'(expStatus.lengthFound),
				64'(status.lengthFound));
			checkValue({checkName, " emptyFound"}, 64'(expStatus.emptyFound),
				64'(status.emptyFound));
			checkValue({checkName, " foundAddr"}, 64'(expStatus.foundAddr),
				64'(status.foundAddr));
			checkValue({checkName, " cachedMem"}, 64'(expStatus.cachedMem),
				64'(status.cachedMem));
			checkValue({checkName, " freeMem"}, 64'(expFreeMem), 64'(freeMem));
			// found only holds a value after a length match
			if (expStatus.lengthFound) begin
				checkValue({checkName, " found"}, 64'(expStatus.found), 64'(status.found));
			end
		end
	end

	task automatic compareNow(input string name);
		checkName = name;
		->checkNow;
	endtask

	// one write driven 1 ns after the edge
	task automatic sendWrite(input ioPort_t port, input logic [31:0] data);
		ioWr.port = port;
		ioWr.data = data;
		@(posedge CLK);
		#1;
		ioWr.port = portNone;
		ioWr.data = '0;
	endtask

	// program entry, launch op and wait for the scan to end
	task automatic runOp(input cacheOp_t op, input freeEntry_t ent);
		sendWrite(portLength, ent.length);
		sendWrite(portSel, {8'h00, ent.sel});
		sendWrite(portControl, ctlWord(op, memKeep));
		refModel(op, ent, memKeep);
		if (op == opWrite) begin
			@(posedge CLK);
			#1;
		end else begin
			while (!status.busy) begin
				@(posedge CLK);
				#1;
			end
			while (status.busy) begin
				@(posedge CLK);
				#1;
			end
			repeat (2) begin
				@(posedge CLK);
				#1;
			end
		end
	endtask

	task automatic memUpdate(input freeMemOp_t memOp, input logic [31:0] length);
		freeEntry_t ent;
		ent.sel = '0;
		ent.length = length;
		sendWrite(portLength, length);
		sendWrite(portControl, ctlWord(opNone, memOp));
		refModel(opNone, ent, memOp);
		compareNow("free memory");
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		freeEntry_t ent;
		logic [31:0] minLen;
		logic [31:0] maxLen;
		logic [31:0] searchLen [5];
		RESETn = 1'b0;
		cena = 1'b1;
		malockf = 1'b0;
		ioWr.port = portNone;
		ioWr.data = '0;
		lfsrState = 16'd66;
		errorCount = 0;
		checkCount = 0;
		modelAddr = '0;
		expStatus = '0;
		expFreeMem = '0;
		ent = '0;
		repeat (8) @(posedge CLK);
		#1;
		RESETn = 1'b1;

		// reset values
		checkValue("reset ready", 64'd0, 64'(ready));
		checkValue("reset coreStart", 64'd0, 64'(coreStart));
		checkValue("reset coreStop", 64'd0, 64'(coreStop));
		checkValue("reset busy", 64'd0, 64'(status.busy));
		checkValue("reset freeMem", 64'd0, 64'(freeMem));

		// clear, empty sum, then fill five free slots
		runOp(opClear, ent);
		runOp(opCalc, ent);
		compareNow("empty sum");
		for (int k = 0; k < 5; k++) begin
			runOp(opFree, ent);
			compareNow("free slot");
			checkValue("free slot address", 64'(128 + k), 64'(status.foundAddr));
			ent.sel = 24'h000100 + 24'(k);
			ent.length = takeRandomBits(16);
			runOp(opWrite, ent);
		end
		runOp(opCalc, ent);
		compareNow("cached sum");

		// searches below, between and above the written lengths
		minLen = modelRam[128].length;
		maxLen = modelRam[128].length;
		for (int k = 129; k < 133; k++) begin
			minLen = (modelRam[k].length < minLen) ? modelRam[k].length : minLen;
			maxLen = (modelRam[k].length > maxLen) ? modelRam[k].length : maxLen;
		end
		searchLen[0] = (minLen == '0) ? '0 : minLen - 32'd1;
		searchLen[1] = minLen;
		searchLen[2] = (minLen + maxLen) >> 1;
		searchLen[3] = maxLen;
		searchLen[4] = maxLen + 32'd1;
		for (int k = 0; k < 5; k++) begin
			ent.length = searchLen[k];
			runOp(opSearch, ent);
			compareNow("length search");
		end

		// descriptor entries in the lower half
		runOp(opEmptySearch, ent);
		compareNow("used descriptor none");
		for (int k = 0; k < 2; k++) begin
			runOp(opEmptyFree, ent);
			compareNow("free descriptor");
			ent.sel = 24'h000A00 + 24'(k);
			ent.length = takeRandomBits(16);
			runOp(opWrite, ent);
		end
		runOp(opEmptySearch, ent);
		compareNow("used descriptor");

		// second clear over the written entries
		runOp(opClear, ent);
		runOp(opCalc, ent);
		compareNow("cleared sum");
		runOp(opEmptySearch, ent);
		compareNow("cleared descriptors");

		// free memory accounting
		memUpdate(memAdd, 32'd1000);
		memUpdate(memAdd, takeRandomBits(20));
		memUpdate(memSub, 32'd99);
		memUpdate(memSub, takeRandomBits(8));
		memUpdate(memClear, 32'd5);
		memUpdate(memSub, 32'd0);

		// core strobes last one cycle
		sendWrite(portControl, 32'd1 << ctlCoreStart);
		checkValue("core start high", 64'd1, 64'(coreStart));
		checkValue("core stop idle", 64'd0, 64'(coreStop));
		@(posedge CLK);
		#1;
		checkValue("core start low", 64'd0, 64'(coreStart));
		sendWrite(portControl, 32'd1 << ctlCoreStop);
		checkValue("core stop high", 64'd1, 64'(coreStop));
		checkValue("core start idle", 64'd0, 64'(coreStart));
		@(posedge CLK);
		#1;
		checkValue("core stop low", 64'd0, 64'(coreStop));

		// ready level
		sendWrite(portControl, 32'd1 << ctlReady);
		checkValue("ready set", 64'd1, 64'(ready));
		@(posedge CLK);
		#1;
		checkValue("ready held", 64'd1, 64'(ready));
		malockf = 1'b1;
		@(posedge CLK);
		#1;
		checkValue("ready locked", 64'd0, 64'(ready));
		malockf = 1'b0;
		@(posedge CLK);
		#1;
		checkValue("ready stays clear", 64'd0, 64'(ready));
		cena = 1'b0;
		sendWrite(portControl, 32'd1 << ctlReady);
		checkValue("ready disabled", 64'd0, 64'(ready));
		cena = 1'b1;

		repeat (2) @(posedge CLK);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// roughly 30 scans of at most 300 cycles plus margin
	initial begin
		cycleCount = 0;
		while (cycleCount < 20000) begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", cycleCount);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
logic/ctxPkg.sv
logic/commandDecoder.sv
logic/freeObjectRam.sv
logic/freeCacheScanner.sv
logic/contextController.sv
verification/contextController_sva.sv
verification/contextControllerTb.sv

// File: Makefile
TOP = contextControllerTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
